// ==== wormhole_link_top.f ====
verilog/wormhole_pkg.sv
verilog/wormhole_adapter_in.sv
verilog/wormhole_flit_fifo.sv
verilog/wormhole_adapter_out.sv
verilog/wormhole_link_top.sv
sim/tb_clock_gen.sv
sim/tb_wormhole_link_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the wormhole link testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "could not remove the old build directory"
  exit $status
fi

verilator --binary --timing --assert \
  -f wormhole_link_top.f \
  --top-module tb_wormhole_link_top
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed"
  exit $status
fi

./obj_dir/Vtb_wormhole_link_top
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi

exit 0

// ==== sim/tb_wormhole_link_top.sv ====
// tb_wormhole_link_top: random packet stimulus, queue model, checker task and watchdog.

`timescale 1ns/10ps

module tb_wormhole_link_top;

  import wormhole_pkg::*;

  localparam int total_packets_lp   = 300;
  localparam int watchdog_cycles_lp = 200 * total_packets_lp;

  logic    clk_w;
  logic    rst_w;
  packet_s packet_i;
  logic    packet_v_i;
  logic    packet_ready_o;
  packet_s packet_o;
  logic    packet_v_o;
  logic    packet_yumi_i;

  integer  seed = 32'hd950_8ae9;
  packet_s exp_q[$];          // accepted packets, in their masked form.
  int      accept_cycle_q[$]; // cycle of each acceptance, same order.
  int      cycle_n = 0;
  int      last_accept_cycle = 0;
  int      last_len = 0;
  bit      accept_seen = 1'b0;
  bit      timed_mode = 1'b0;
  packet_s exp_pkt;
  int      accept_cycle;

  tb_clock_gen clk_gen0 (
    .clk_o (clk_w),
    .rst_o (rst_w)
  );

  wormhole_link_top dut0 (
    .clk_i          (clk_w),
    .rst_i          (rst_w),
    .packet_i       (packet_i),
    .packet_v_i     (packet_v_i),
    .packet_ready_o (packet_ready_o),
    .packet_o       (packet_o),
    .packet_v_o     (packet_v_o),
    .packet_yumi_i  (packet_yumi_i)
  );

  task automatic end_with_failure();
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first error.");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Fail at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
      end_with_failure();
    end
  endtask

  // true with a chance of pct percent.
  function automatic bit chance(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  // a negative len_sel picks a random length.
  function automatic packet_s make_packet(input int len_sel);
    packet_s p;
    p = {$random(seed), $random(seed)};
    if (len_sel >= 0) begin
      p.len = len_sel[1:0];
    end
    return p;
  endfunction

  // only flits 0 to len are sent; the rest of the rebuilt packet reads zero.
  function automatic packet_s expected_packet(input packet_s p);
    logic [$bits(packet_s)-1:0] keep;
    int                         k;
    keep = '0;
    for (k = 0; k < max_flits_lp; k++) begin
      if (k <= int'(p.len)) begin
        keep[k*flit_width_lp +: flit_width_lp] = '1;
      end
    end
    return packet_s'(p & keep);
  endfunction

  // the model samples handshakes at the rising edge, inputs having settled 1 ns after the last one.
  always @(posedge clk_w) begin
    if (!rst_w) begin
      if (accept_seen && (cycle_n - last_accept_cycle) <= last_len + 1) begin
        check_value("packet_ready_o", 64'(1'b0), 64'(packet_ready_o)); // still serializing.
      end
      if (packet_v_i && packet_ready_o) begin
        exp_q.push_back(expected_packet(packet_i));
        accept_cycle_q.push_back(cycle_n);
        last_accept_cycle = cycle_n;
        last_len = int'(packet_i.len);
        accept_seen = 1'b1;
      end
      if (packet_yumi_i) begin
        if (!packet_v_o) begin
          $display("Error at %0t ns: yumi was given while no packet was presented.", $time);
          end_with_failure();
        end else if (exp_q.size() == 0) begin
          $display("Error at %0t ns: a packet came out that was never sent.", $time);
          end_with_failure();
        end else begin
          exp_pkt = exp_q.pop_front();
          accept_cycle = accept_cycle_q.pop_front();
          check_value("packet_o", 64'(exp_pkt), 64'(packet_o));
          if (timed_mode) begin
            check_value("packet latency", 64'(int'(exp_pkt.len) + 3),
                        64'(cycle_n - accept_cycle));
          end
        end
      end
    end
    cycle_n++;
  end

  // sends count packets; a valid that was not taken stays up with the same packet.
  task automatic run_packets(input int count, input int len_sel, input int v_pct,
                             input int yumi_pct);
    int sent;
    bit took;
    sent = 0;
    packet_i = make_packet(len_sel);
    packet_v_i = chance(v_pct);
    while (sent < count) begin
      @(posedge clk_w);
      took = packet_v_i && packet_ready_o;
      #1;
      if (took) begin
        sent++;
        packet_i = make_packet(len_sel);
      end
      if (took || !packet_v_i) begin
        packet_v_i = (sent < count) && chance(v_pct);
      end
      packet_yumi_i = packet_v_o && chance(yumi_pct);
    end
  endtask

  // empties the link, then checks that no packet follows the last expected one.
  task automatic drain(input int yumi_pct);
    int n;
    packet_v_i = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk_w);
      #1;
      packet_yumi_i = packet_v_o && chance(yumi_pct);
    end
    packet_yumi_i = 1'b0;
    // long enough for any flit still in the link to reach the output.
    for (n = 0; n < 3 * max_flits_lp; n++) begin
      @(posedge clk_w);
      #1;
      check_value("packet_v_o", 64'(1'b0), 64'(packet_v_o));
    end
  endtask

  initial begin
    packet_i = '0;
    packet_v_i = 1'b0;
    packet_yumi_i = 1'b0;
    while (rst_w) begin
      @(negedge clk_w);
      if (rst_w) begin
        check_value("packet_v_o", 64'(1'b0), 64'(packet_v_o));
      end
    end
    check_value("packet_v_o", 64'(1'b0), 64'(packet_v_o));
    check_value("packet_ready_o", 64'(1'b1), 64'(packet_ready_o));
    @(posedge clk_w);
    #1;
    run_packets(40, 3, 70, 60); // full-length packets.
    drain(60);
    run_packets(60, -1, 70, 60); // random lengths, short ones come back masked.
    drain(60);
    run_packets(150, -1, 40, 25); // mixed lengths, slow producer and consumer.
    drain(30);
    timed_mode = 1'b1;
    run_packets(50, 3, 100, 100);
    drain(100);
    timed_mode = 1'b0;
    $display("Finished with no errors");
    $finish;
  end

  initial begin
    repeat (watchdog_cycles_lp) @(posedge clk_w);
    $display("Timeout: the tests did not finish within %0d cycles.", watchdog_cycles_lp);
    $display("Finished with errors");
    $fatal(1, "watchdog expired.");
  end

endmodule

// ==== sim/tb_clock_gen.sv ====
// tb_clock_gen: testbench clock and synchronous reset generator.

`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  // 10 ns period, first rising edge at 5 ns.
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset covers five rising edges and drops just after the fifth.
  initial begin
    rst_o = 1'b1;
    repeat (5) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

// ==== verilog/wormhole_link_top.sv ====
// wormhole_link_top: packet serializer, flit buffer and packet deserializer in a chain.

`timescale 1ns/10ps

module wormhole_link_top (
  input  logic                  clk_i,
  input  logic                  rst_i,

  input  wormhole_pkg::packet_s packet_i,
  input  logic                  packet_v_i,
  output logic                  packet_ready_o,

  output wormhole_pkg::packet_s packet_o,
  output logic                  packet_v_o,
  input  logic                  packet_yumi_i
);

  import wormhole_pkg::*;

  link_s ser_link;  // adapter in to buffer.
  logic  ser_ready;
  link_s fifo_link; // buffer to adapter out.
  logic  des_ready;

  wormhole_adapter_in ser0 (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .packet_i       (packet_i),
    .packet_v_i     (packet_v_i),
    .packet_ready_o (packet_ready_o),
    .link_o         (ser_link),
    .link_ready_i   (ser_ready)
  );

  // stands in for the network between the two ends.
  wormhole_flit_fifo fifo0 (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .link_i       (ser_link),
    .link_ready_o (ser_ready),
    .link_o       (fifo_link),
    .link_ready_i (des_ready)
  );

  wormhole_adapter_out des0 (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .link_i        (fifo_link),
    .link_ready_o  (des_ready),
    .packet_o      (packet_o),
    .packet_v_o    (packet_v_o),
    .packet_yumi_i (packet_yumi_i)
  );

endmodule

// ==== verilog/wormhole_adapter_out.sv ====
// wormhole_adapter_out: dynamic-length flit deserializer that holds the packet until yumi.

`timescale 1ns/10ps

module wormhole_adapter_out (
  input  logic                  clk_i,
  input  logic                  rst_i,

  input  wormhole_pkg::link_s   link_i,
  output logic                  link_ready_o,

  output wormhole_pkg::packet_s packet_o,
  output logic                  packet_v_o,
  input  logic                  packet_yumi_i
);

  import wormhole_pkg::*;

  des_state_e                                 state_r;
  logic [max_flits_lp-1:0][flit_width_lp-1:0] buf_r;
  logic [flit_cnt_width_lp-1:0]               cnt_r;
  logic [flit_cnt_width_lp-1:0]               last_r;

  header_s                      header_li;
  logic                         recv;
  logic [flit_cnt_width_lp-1:0] last_idx;

  // only meaningful on the first flit of a packet.
  assign header_li = link_i.data[$bits(header_s)-1:0];

  assign link_ready_o = (state_r == des_collect);
  assign packet_v_o   = (state_r == des_full);
  assign packet_o     = buf_r;

  assign recv = link_i.v & link_ready_o;

  // the header flit brings the length, later flits use the stored copy.
  // expecting len + 1 flits means the last one has index len.
  assign last_idx = (cnt_r == '0) ? header_li.len : last_r;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= des_collect;
      cnt_r   <= '0;
      last_r  <= '0;
    end else begin
      case (state_r)
        des_collect: begin
          if (recv) begin
            last_r <= last_idx;
            if (cnt_r == last_idx) begin
              state_r <= des_full;
              cnt_r   <= '0;
            end else begin
              cnt_r <= cnt_r + 1'b1;
            end
          end
        end
        des_full: begin
          if (packet_yumi_i) begin
            state_r <= des_collect;
          end
        end
        default: begin
          state_r <= des_collect;
        end
      endcase
    end
  end

  // flits land in their slot from the low end.
  // clearing on yumi leaves the unsent high flits of a short packet at zero.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      buf_r <= '0;
    end else if (packet_v_o && packet_yumi_i) begin
      buf_r <= '0;
    end else if (recv) begin
      buf_r[cnt_r] <= link_i.data;
    end
  end

  // the consumer may only take a packet that is presented.
  a_yumi_when_valid: assert property (
    @(posedge clk_i) disable iff (rst_i)
    packet_yumi_i |-> packet_v_o
  ) else $error("yumi given with no packet at the adapter out.");

  // a presented packet stays put until it is taken, so no flit slipped in.
  a_no_flit_while_full: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (packet_v_o && !packet_yumi_i) |=> (packet_v_o && $stable(packet_o))
  ) else $error("packet at the adapter out changed before yumi.");

endmodule

// ==== verilog/wormhole_flit_fifo.sv ====
// wormhole_flit_fifo: two-entry flit buffer with ready-and on both sides.

`timescale 1ns/10ps

module wormhole_flit_fifo (
  input  logic                clk_i,
  input  logic                rst_i,

  input  wormhole_pkg::link_s link_i,
  output logic                link_ready_o,

  output wormhole_pkg::link_s link_o,
  input  logic                link_ready_i
);

  import wormhole_pkg::*;

  logic [1:0][flit_width_lp-1:0] mem_r;
  logic                          wr_ptr_r;
  logic                          rd_ptr_r;
  logic [1:0]                    count_r;

  logic wr_en;
  logic rd_en;

  // ready only looks at occupancy, so it never depends on the reader.
  assign link_ready_o = (count_r != 2'd2);
  assign link_o.v     = (count_r != 2'd0);
  assign link_o.data  = mem_r[rd_ptr_r];

  assign wr_en = link_i.v & link_ready_o;
  assign rd_en = link_o.v & link_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end else begin
      if (wr_en) begin
        wr_ptr_r <= ~wr_ptr_r;
      end
      if (rd_en) begin
        rd_ptr_r <= ~rd_ptr_r;
      end
      // a read and a write together leave the count alone.
      case ({wr_en, rd_en})
        2'b10:   count_r <= count_r + 2'd1;
        2'b01:   count_r <= count_r - 2'd1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_r[wr_ptr_r] <= link_i.data;
    end
  end

  // with equal pointers the buffer is either empty or full, and a write needs room.
  a_no_write_full: assert property (
    @(posedge clk_i) disable iff (rst_i)
    wr_en |-> ((wr_ptr_r != rd_ptr_r) || (count_r == 2'd0))
  ) else $error("flit buffer written while full.");

  // a read needs a slot holding data.
  a_no_read_empty: assert property (
    @(posedge clk_i) disable iff (rst_i)
    rd_en |-> ((wr_ptr_r != rd_ptr_r) || (count_r == 2'd2))
  ) else $error("flit buffer read while empty.");

endmodule

// ==== verilog/wormhole_adapter_in.sv ====
// wormhole_adapter_in: serializes a whole packet into flits on a ready-and link.

`timescale 1ns/10ps

module wormhole_adapter_in (
  input  logic                 clk_i,
  input  logic                 rst_i,

  input  wormhole_pkg::packet_s packet_i,
  input  logic                 packet_v_i,
  output logic                 packet_ready_o,

  output wormhole_pkg::link_s  link_o,
  input  logic                 link_ready_i
);

  import wormhole_pkg::*;

  ser_state_e                  state_r;
  packet_s                     packet_r;
  logic [flit_cnt_width_lp-1:0] cnt_r;

  logic [max_flits_lp-1:0][flit_width_lp-1:0] flits;
  logic                                       accept;
  logic                                       send;
  logic                                       last_flit;

  // a new packet is taken only when the previous one is fully sent.
  assign packet_ready_o = (state_r == ser_idle);
  assign accept         = packet_v_i & packet_ready_o;

  // the registered packet viewed as flits, flit 0 lowest.
  assign flits = packet_r;

  assign link_o.v    = (state_r == ser_send);
  assign link_o.data = flits[cnt_r]; // held while the counter waits.

  assign send      = link_o.v & link_ready_i;
  assign last_flit = (cnt_r == packet_r.len); // len counts flits after the header.

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= ser_idle;
      cnt_r   <= '0;
    end else begin
      case (state_r)
        ser_idle: begin
          if (accept) begin
            state_r <= ser_send;
            cnt_r   <= '0;
          end
        end
        ser_send: begin
          if (send) begin
            if (last_flit) begin
              state_r <= ser_idle;
              cnt_r   <= '0;
            end else begin
              cnt_r <= cnt_r + 1'b1;
            end
          end
        end
        default: begin
          state_r <= ser_idle;
        end
      endcase
    end
  end

  // the payload register loads on acceptance only.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      packet_r <= packet_i;
    end
  end

  // a stalled flit must stay valid and unchanged until the buffer takes it.
  a_hold_under_backpressure: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (link_o.v && !link_ready_i) |=> (link_o.v && $stable(link_o.data))
  ) else $error("adapter in changed a flit that was not yet taken.");

endmodule

// ==== verilog/wormhole_pkg.sv ====
// wormhole link sizes, flit link and packet structs, adapter state enums.

package wormhole_pkg;

  // one flit on the narrow link.
  localparam int flit_width_lp = 16;

  // header fields, kept in the low bits of the first flit.
  localparam int cord_width_lp = 4;
  localparam int len_width_lp  = 2; // flits after the header flit, 0 to 3.

  // the full packet is 64 bits, which is exactly four flits.
  localparam int payload_width_lp  = 58;
  localparam int max_flits_lp      = 4;
  localparam int flit_cnt_width_lp = 2;

  // forward half of a ready-and flit link. ready runs on its own wire.
  typedef struct packed {
    logic                     v;
    logic [flit_width_lp-1:0] data;
  } link_s;

  // header as seen in the low six bits of flit 0.
  typedef struct packed {
    logic [len_width_lp-1:0]  len;
    logic [cord_width_lp-1:0] cord;
  } header_s;

  // packet layout is payload, length, coordinate, coordinate lowest.
  typedef struct packed {
    logic [payload_width_lp-1:0] payload;
    logic [len_width_lp-1:0]     len;
    logic [cord_width_lp-1:0]    cord;
  } packet_s;

  // serializer states.
  typedef enum logic {
    ser_idle,
    ser_send
  } ser_state_e;

  // deserializer states.
  typedef enum logic {
    des_collect,
    des_full
  } des_state_e;

endpackage
